//--- design/classifier_pkg.sv
`default_nettype none

package classifier_pkg;

  // pipeline shape
  localparam int NUM_GROUPS = 2;
  localparam int NUM_STAGES = 4;
  localparam int PIPE_LATENCY = 7;

  // table geometry
  localparam int SEG_W = 4;
  localparam int SEG_DEPTH = 1 << SEG_W;
  localparam int RULE_INDEX_W = 5;
  localparam int RULE_DEPTH = 1 << RULE_INDEX_W;
  localparam int RULE_ID_W = 11;
  localparam int STAGE_W = $clog2(NUM_STAGES);
  localparam int GROUP_W = $clog2(NUM_GROUPS);

  // wishbone port
  localparam int WB_ADR_W = 12;
  localparam int WB_DAT_W = 32;

  // address map, region in adr[11:10]
  localparam logic [1:0] REGION_SEG = 2'd0;
  localparam logic [1:0] REGION_RULE = 2'd1;

  // rule word select in adr[1:0]
  localparam logic [1:0] RULE_WORD_PREFIX = 2'd0;
  localparam logic [1:0] RULE_WORD_CTRL = 2'd1;
  localparam logic [1:0] RULE_WORD_LINK = 2'd2;

  // group bases are packed one per byte in a segment write
  localparam int SEG_BASE_STRIDE = 8;

  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] port_t;
  typedef logic [7:0] proto_t;
  typedef logic [SEG_W-1:0] seg_index_t;
  typedef logic [RULE_INDEX_W-1:0] rule_index_t;
  typedef logic [RULE_ID_W-1:0] rule_id_t;
  typedef logic [5:0] prefix_len_t;
  typedef logic [STAGE_W-1:0] stage_sel_t;
  typedef logic [GROUP_W-1:0] group_sel_t;

  typedef struct packed {
    ip_addr_t src_ip;
    ip_addr_t dst_ip;
    port_t    src_port;
    port_t    dst_port;
    proto_t   proto;
  } tuple_t;

  typedef struct packed {
    logic        valid;
    logic        proto_any;
    proto_t      proto;
    prefix_len_t prefix_len;
    ip_addr_t    prefix;
    rule_id_t    rule_id;
    rule_index_t next_index;
  } rule_entry_t;

  typedef struct packed {
    logic     hit;
    rule_id_t rule_id;
  } group_result_t;

  // one packet in flight through the search chain
  typedef struct packed {
    logic                                valid;
    tuple_t                              tuple;
    rule_index_t [NUM_GROUPS-1:0]        index;
    group_result_t [NUM_GROUPS-1:0]      result;
  } search_token_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                         en;
    seg_index_t                   seg;
    rule_index_t [NUM_GROUPS-1:0] base;
  } seg_write_t;

  typedef struct packed {
    logic                en;
    stage_sel_t          stage;
    group_sel_t          group;
    rule_index_t         index;
    logic [1:0]          word;
    logic [WB_DAT_W-1:0] data;
  } rule_write_t;

endpackage

`default_nettype wire

//--- design/table_config_port.sv
`timescale 1ns/1ps
`default_nettype none

module table_config_port (
  input  logic                        clk,
  input  logic                        rst,
  input  classifier_pkg::wb_req_t     wb,
  output logic                        ack,
  output classifier_pkg::seg_write_t  seg_write,
  output classifier_pkg::rule_write_t rule_write
);

  logic       held;
  logic       req;
  logic [1:0] region;
  logic       write_seg;
  logic       write_rule;

  // a request is served once, then waits for stb to drop
  assign req = wb.cyc && wb.stb && !ack && !held;
  assign region = wb.adr[11:10];

  assign write_seg = req && wb.we && (region == classifier_pkg::REGION_SEG);
  assign write_rule = req && wb.we && (region == classifier_pkg::REGION_RULE);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack <= 1'b0;
      held <= 1'b0;
    end
    else
    begin
      ack <= req;
      if (ack)
      begin
        held <= 1'b1;
      end
      else if (!(wb.cyc && wb.stb))
      begin
        held <= 1'b0;
      end
    end
  end

  // write pulses line up with ack
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      seg_write.en <= 1'b0;
      rule_write.en <= 1'b0;
    end
    else
    begin
      seg_write.en <= write_seg;
      rule_write.en <= write_rule;
    end

    seg_write.seg <= wb.adr[classifier_pkg::SEG_W-1:0];
    for (int g = 0; g < classifier_pkg::NUM_GROUPS; g++)
    begin
      seg_write.base[g] <=
        wb.dat[g*classifier_pkg::SEG_BASE_STRIDE +: classifier_pkg::RULE_INDEX_W];
    end

    // rule address: stage, group, index, word
    rule_write.stage <= wb.adr[9:8];
    rule_write.group <= wb.adr[7];
    rule_write.index <= wb.adr[6:2];
    rule_write.word <= wb.adr[1:0];
    rule_write.data <= wb.dat;
  end

endmodule

`default_nettype wire

//--- design/tuple_hash_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tuple_hash_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          tuple_valid,
  input  classifier_pkg::tuple_t        tuple,
  input  classifier_pkg::seg_write_t    seg_write,
  output classifier_pkg::search_token_t token
);

  localparam int NIBBLES = $bits(classifier_pkg::tuple_t) / classifier_pkg::SEG_W;

  classifier_pkg::seg_index_t  hash;
  classifier_pkg::seg_index_t  seg_r;
  classifier_pkg::tuple_t      tuple_r;
  logic                        valid_r;
  classifier_pkg::rule_index_t seg_base [classifier_pkg::SEG_DEPTH][classifier_pkg::NUM_GROUPS];

  // fold every nibble of the tuple into one segment index
  always_comb
  begin
    hash = '0;
    for (int i = 0; i < NIBBLES; i++)
    begin
      hash ^= tuple[i*classifier_pkg::SEG_W +: classifier_pkg::SEG_W];
    end
  end

  // segment table, one base index per group
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < classifier_pkg::SEG_DEPTH; s++)
      begin
        for (int g = 0; g < classifier_pkg::NUM_GROUPS; g++)
        begin
          seg_base[s][g] <= '0;
        end
      end
    end
    else if (seg_write.en)
    begin
      for (int g = 0; g < classifier_pkg::NUM_GROUPS; g++)
      begin
        seg_base[seg_write.seg][g] <= seg_write.base[g];
      end
    end
  end

  // cycle 1 holds tuple and hash, cycle 2 builds the token
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_r <= 1'b0;
      token.valid <= 1'b0;
    end
    else
    begin
      valid_r <= tuple_valid;
      token.valid <= valid_r;
    end

    tuple_r <= tuple;
    seg_r <= hash;
    token.tuple <= tuple_r;
    for (int g = 0; g < classifier_pkg::NUM_GROUPS; g++)
    begin
      token.index[g] <= seg_base[seg_r][g];
      token.result[g] <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/rule_search_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rule_search_stage #(
  parameter int STAGE_ID = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  classifier_pkg::rule_write_t   rule_write,
  input  classifier_pkg::search_token_t token_in,
  output classifier_pkg::search_token_t token_out
);

  localparam int NG = classifier_pkg::NUM_GROUPS;
  localparam int DEPTH = classifier_pkg::RULE_DEPTH;
  localparam classifier_pkg::stage_sel_t STAGE_SEL = classifier_pkg::stage_sel_t'(STAGE_ID);

  // rule tables kept as one array per field
  logic                         valid_mem     [NG][DEPTH];
  logic                         proto_any_mem [NG][DEPTH];
  classifier_pkg::proto_t       proto_mem     [NG][DEPTH];
  classifier_pkg::prefix_len_t  prefix_len_mem[NG][DEPTH];
  classifier_pkg::ip_addr_t     prefix_mem    [NG][DEPTH];
  classifier_pkg::rule_id_t     rule_id_mem   [NG][DEPTH];
  classifier_pkg::rule_index_t  next_mem      [NG][DEPTH];

  classifier_pkg::rule_entry_t   entry  [NG];
  classifier_pkg::ip_addr_t      mask   [NG];
  logic                          hit    [NG];
  classifier_pkg::group_result_t best   [NG];
  classifier_pkg::prefix_len_t   plen   [NG];
  logic                          sel_stage;

  assign sel_stage = rule_write.en && (rule_write.stage == STAGE_SEL);

  // valid and link clear so an unwritten entry misses and walks to index 0
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int g = 0; g < NG; g++)
      begin
        for (int i = 0; i < DEPTH; i++)
        begin
          valid_mem[g][i] <= 1'b0;
          next_mem[g][i] <= '0;
        end
      end
    end
    else if (sel_stage)
    begin
      case (rule_write.word)
        classifier_pkg::RULE_WORD_PREFIX:
        begin
          prefix_mem[rule_write.group][rule_write.index] <= rule_write.data;
        end
        classifier_pkg::RULE_WORD_CTRL:
        begin
          valid_mem[rule_write.group][rule_write.index] <= rule_write.data[31];
          proto_any_mem[rule_write.group][rule_write.index] <= rule_write.data[16];
          proto_mem[rule_write.group][rule_write.index] <= rule_write.data[15:8];
          prefix_len_mem[rule_write.group][rule_write.index] <= rule_write.data[5:0];
        end
        classifier_pkg::RULE_WORD_LINK:
        begin
          rule_id_mem[rule_write.group][rule_write.index] <= rule_write.data[26:16];
          next_mem[rule_write.group][rule_write.index] <= rule_write.data[4:0];
        end
        default:
        begin
        end
      endcase
    end
  end

  always_comb
  begin
    for (int g = 0; g < NG; g++)
    begin
      entry[g].valid = valid_mem[g][token_in.index[g]];
      entry[g].proto_any = proto_any_mem[g][token_in.index[g]];
      entry[g].proto = proto_mem[g][token_in.index[g]];
      entry[g].prefix_len = prefix_len_mem[g][token_in.index[g]];
      entry[g].prefix = prefix_mem[g][token_in.index[g]];
      entry[g].rule_id = rule_id_mem[g][token_in.index[g]];
      entry[g].next_index = next_mem[g][token_in.index[g]];

      // lengths past 32 behave as a full host match
      plen[g] = (entry[g].prefix_len > 6'd32) ? 6'd32 : entry[g].prefix_len;
      mask[g] = ~(32'hFFFF_FFFF >> plen[g]);

      hit[g] = entry[g].valid
            && (entry[g].proto_any || (entry[g].proto == token_in.tuple.proto))
            && (((token_in.tuple.dst_ip ^ entry[g].prefix) & mask[g]) == '0);

      best[g] = token_in.result[g];
      if (hit[g] && (!token_in.result[g].hit || entry[g].rule_id > token_in.result[g].rule_id))
      begin
        best[g].hit = 1'b1;
        best[g].rule_id = entry[g].rule_id;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      token_out.valid <= 1'b0;
    end
    else
    begin
      token_out.valid <= token_in.valid;
    end

    token_out.tuple <= token_in.tuple;
    for (int g = 0; g < NG; g++)
    begin
      token_out.index[g] <= entry[g].next_index;
      token_out.result[g] <= best[g];
    end
  end

endmodule

`default_nettype wire

//--- design/best_rule_select.sv
`timescale 1ns/1ps
`default_nettype none

module best_rule_select (
  input  logic                          clk,
  input  logic                          rst,
  input  classifier_pkg::search_token_t token,
  output logic                          result_valid,
  output logic                          match,
  output classifier_pkg::rule_id_t      rule_id
);

  logic                     any_hit;
  classifier_pkg::rule_id_t best_id;

  // highest id among the groups that hit, zero otherwise
  always_comb
  begin
    any_hit = 1'b0;
    best_id = '0;
    for (int g = 0; g < classifier_pkg::NUM_GROUPS; g++)
    begin
      if (token.result[g].hit && (!any_hit || token.result[g].rule_id > best_id))
      begin
        best_id = token.result[g].rule_id;
      end
      any_hit = any_hit | token.result[g].hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_valid <= 1'b0;
      match <= 1'b0;
    end
    else
    begin
      result_valid <= token.valid;
      // no match reported between results
      match <= token.valid && any_hit;
    end

    rule_id <= best_id;
  end

endmodule

`default_nettype wire

//--- design/packet_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module packet_classifier (
  input  logic                     clk,
  input  logic                     rst,
  input  classifier_pkg::wb_req_t  wb,
  output logic                     ack,
  input  logic                     tuple_valid,
  input  classifier_pkg::tuple_t   tuple,
  output logic                     result_valid,
  output logic                     match,
  output classifier_pkg::rule_id_t rule_id
);

  classifier_pkg::seg_write_t    seg_write;
  classifier_pkg::rule_write_t   rule_write;
  // token entering each search stage, last one feeds the selector
  classifier_pkg::search_token_t stage_token [classifier_pkg::NUM_STAGES+1];

  table_config_port u_config (
    .clk        (clk),
    .rst        (rst),
    .wb         (wb),
    .ack        (ack),
    .seg_write  (seg_write),
    .rule_write (rule_write)
  );

  tuple_hash_stage u_hash (
    .clk         (clk),
    .rst         (rst),
    .tuple_valid (tuple_valid),
    .tuple       (tuple),
    .seg_write   (seg_write),
    .token       (stage_token[0])
  );

  for (genvar s = 0; s < classifier_pkg::NUM_STAGES; s++)
  begin : g_stage
    rule_search_stage #(
      .STAGE_ID (s)
    ) u_search (
      .clk        (clk),
      .rst        (rst),
      .rule_write (rule_write),
      .token_in   (stage_token[s]),
      .token_out  (stage_token[s+1])
    );
  end

  best_rule_select u_select (
    .clk          (clk),
    .rst          (rst),
    .token        (stage_token[classifier_pkg::NUM_STAGES]),
    .result_valid (result_valid),
    .match        (match),
    .rule_id      (rule_id)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  // reset held for the first 10 rising edges
  initial
  begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/packet_classifier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_classifier_tb;

  localparam int LATENCY = 7;
  localparam int ACK_TIMEOUT = 20;
  localparam int RESULT_TIMEOUT = 50;
  localparam int RESET_TIMEOUT = 50;

  logic                     clk;
  logic                     rst;
  classifier_pkg::wb_req_t  wb;
  logic                     ack;
  logic                     tuple_valid;
  classifier_pkg::tuple_t   tuple;
  logic                     result_valid;
  logic                     match;
  classifier_pkg::rule_id_t rule_id;

  integer seed;
  int     negedge_count;

  // captured results, in arrival order
  logic                     got_match [$];
  classifier_pkg::rule_id_t got_id [$];
  int                       got_cycle [$];
  classifier_pkg::tuple_t   batch_q [$];

  // shadow copy of every table written
  logic [4:0]  model_base   [16][2];
  logic        model_valid  [4][2][32];
  logic        model_any    [4][2][32];
  logic [7:0]  model_proto  [4][2][32];
  logic [5:0]  model_plen   [4][2][32];
  logic [31:0] model_prefix [4][2][32];
  logic [10:0] model_rid    [4][2][32];
  logic [4:0]  model_next   [4][2][32];

  tb_clock_gen u_clock (
    .clk (clk),
    .rst (rst)
  );

  packet_classifier u_dut (
    .clk          (clk),
    .rst          (rst),
    .wb           (wb),
    .ack          (ack),
    .tuple_valid  (tuple_valid),
    .tuple        (tuple),
    .result_valid (result_valid),
    .match        (match),
    .rule_id      (rule_id)
  );

  // sample outputs half a cycle after they change
  always @(negedge clk)
  begin
    negedge_count = negedge_count + 1;
    if (!rst && result_valid)
    begin
      got_match.push_back(match);
      got_id.push_back(rule_id);
      got_cycle.push_back(negedge_count);
    end
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      stop_on_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [3:0] hash_tuple(input classifier_pkg::tuple_t t);
    logic [103:0] bits;
    logic [3:0]   h;
    bits = t;
    h = 4'd0;
    for (int i = 0; i < 26; i++)
    begin
      h = h ^ bits[i*4 +: 4];
    end
    return h;
  endfunction

  function automatic logic prefix_matches(input logic [31:0] ip, input logic [31:0] prefix,
                                          input logic [5:0] len);
    int   n;
    logic same;
    n = (len > 6'd32) ? 32 : int'(len);
    same = 1'b1;
    for (int b = 0; b < n; b++)
    begin
      if (ip[31-b] != prefix[31-b])
      begin
        same = 1'b0;
      end
    end
    return same;
  endfunction

  // returns {match, rule_id}
  function automatic logic [11:0] predict_result(input classifier_pkg::tuple_t t);
    logic [3:0]  seg;
    logic [4:0]  idx [2];
    logic        hit [2];
    logic [10:0] best [2];
    logic [4:0]  i;
    logic        ok;
    logic        any_hit;
    logic [10:0] top;
    seg = hash_tuple(t);
    for (int g = 0; g < 2; g++)
    begin
      idx[g] = model_base[seg][g];
      hit[g] = 1'b0;
      best[g] = 11'd0;
    end
    for (int s = 0; s < 4; s++)
    begin
      for (int g = 0; g < 2; g++)
      begin
        i = idx[g];
        ok = model_valid[s][g][i]
          && (model_any[s][g][i] || (model_proto[s][g][i] == t.proto))
          && prefix_matches(t.dst_ip, model_prefix[s][g][i], model_plen[s][g][i]);
        if (ok && (!hit[g] || (model_rid[s][g][i] > best[g])))
        begin
          hit[g] = 1'b1;
          best[g] = model_rid[s][g][i];
        end
        idx[g] = model_next[s][g][i];
      end
    end
    any_hit = 1'b0;
    top = 11'd0;
    for (int g = 0; g < 2; g++)
    begin
      if (hit[g])
      begin
        any_hit = 1'b1;
        if (best[g] > top)
        begin
          top = best[g];
        end
      end
    end
    return {any_hit, top};
  endfunction

  task automatic model_clear();
    for (int s = 0; s < 16; s++)
    begin
      model_base[s][0] = 5'd0;
      model_base[s][1] = 5'd0;
    end
    for (int s = 0; s < 4; s++)
    begin
      for (int g = 0; g < 2; g++)
      begin
        for (int i = 0; i < 32; i++)
        begin
          model_valid[s][g][i] = 1'b0;
          model_any[s][g][i] = 1'b0;
          model_proto[s][g][i] = 8'd0;
          model_plen[s][g][i] = 6'd0;
          model_prefix[s][g][i] = 32'd0;
          model_rid[s][g][i] = 11'd0;
          model_next[s][g][i] = 5'd0;
        end
      end
    end
  endtask

  // decode of the address map, regions 2 and 3 are ignored
  task automatic shadow_write(input logic [11:0] adr, input logic [31:0] dat);
    if (adr[11:10] == 2'd0)
    begin
      model_base[adr[3:0]][0] = dat[4:0];
      model_base[adr[3:0]][1] = dat[12:8];
    end
    else if (adr[11:10] == 2'd1)
    begin
      if (adr[1:0] == 2'd0)
      begin
        model_prefix[adr[9:8]][adr[7]][adr[6:2]] = dat;
      end
      else if (adr[1:0] == 2'd1)
      begin
        model_valid[adr[9:8]][adr[7]][adr[6:2]] = dat[31];
        model_any[adr[9:8]][adr[7]][adr[6:2]] = dat[16];
        model_proto[adr[9:8]][adr[7]][adr[6:2]] = dat[15:8];
        model_plen[adr[9:8]][adr[7]][adr[6:2]] = dat[5:0];
      end
      else if (adr[1:0] == 2'd2)
      begin
        model_rid[adr[9:8]][adr[7]][adr[6:2]] = dat[26:16];
        model_next[adr[9:8]][adr[7]][adr[6:2]] = dat[4:0];
      end
    end
  endtask

  // one wishbone cycle, ack expected one cycle later for one cycle
  task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] dat);
    classifier_pkg::wb_req_t req;
    int                      waited;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = we;
    req.adr = adr;
    req.dat = dat;
    @(posedge clk);
    wb <= req;
    @(negedge clk);
    waited = 0;
    while (!ack)
    begin
      if (waited >= ACK_TIMEOUT)
      begin
        stop_on_failure("timeout: no wishbone ack for a request");
      end
      @(negedge clk);
      waited++;
    end
    check_value("ack_delay", 64'(waited), 64'd1);
    @(posedge clk);
    wb <= '0;
    @(negedge clk);
    check_value("ack", 64'(ack), 64'd0);
    if (we)
    begin
      shadow_write(adr, dat);
    end
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat);
    bus_cycle(1'b1, adr, dat);
  endtask

  function automatic logic [11:0] rule_addr(input logic [1:0] stage, input logic group,
                                            input logic [4:0] index, input logic [1:0] word);
    return {2'b01, stage, group, index, word};
  endfunction

  task automatic program_seg(input logic [3:0] seg, input logic [4:0] base0,
                             input logic [4:0] base1);
    wb_write({8'h00, seg}, {19'd0, base1, 3'd0, base0});
  endtask

  task automatic program_rule(input logic [1:0] stage, input logic group, input logic [4:0] index,
                              input logic valid, input logic any, input logic [7:0] proto,
                              input logic [5:0] plen, input logic [31:0] prefix,
                              input logic [10:0] rid, input logic [4:0] next);
    wb_write(rule_addr(stage, group, index, 2'd0), prefix);
    wb_write(rule_addr(stage, group, index, 2'd1), {valid, 14'd0, any, proto, 2'd0, plen});
    wb_write(rule_addr(stage, group, index, 2'd2), {5'd0, rid, 11'd0, next});
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(posedge clk);
    while (rst)
    begin
      if (waited >= RESET_TIMEOUT)
      begin
        stop_on_failure("timeout: reset never released");
      end
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic clear_results();
    got_match.delete();
    got_id.delete();
    got_cycle.delete();
  endtask

  // one tuple, checked against a directed expectation and the fixed latency
  task automatic run_single(input classifier_pkg::tuple_t t, input logic exp_match,
                            input logic [10:0] exp_id);
    int sent_at;
    int waited;
    clear_results();
    @(posedge clk);
    tuple_valid <= 1'b1;
    tuple <= t;
    @(posedge clk);
    tuple_valid <= 1'b0;
    // counted from the cycle that presented the tuple
    sent_at = negedge_count;
    waited = 1;
    while (got_match.size() == 0)
    begin
      if (waited >= RESULT_TIMEOUT)
      begin
        stop_on_failure("timeout: no result for a classified tuple");
      end
      @(posedge clk);
      waited++;
    end
    check_value("latency", 64'(got_cycle[0] - sent_at), 64'(LATENCY));
    check_value("match", 64'(got_match[0]), 64'(exp_match));
    check_value("rule_id", 64'(got_id[0]), 64'(exp_id));
    repeat (2) @(posedge clk);
    check_value("result_count", 64'(got_match.size()), 64'd1);
  endtask

  // back to back tuples from batch_q, each checked against the model
  task automatic send_batch();
    logic [11:0] want [$];
    logic [11:0] p;
    int          n;
    int          waited;
    clear_results();
    n = batch_q.size();
    for (int k = 0; k < n; k++)
    begin
      @(posedge clk);
      tuple_valid <= 1'b1;
      tuple <= batch_q[k];
      want.push_back(predict_result(batch_q[k]));
    end
    @(posedge clk);
    tuple_valid <= 1'b0;
    waited = 0;
    while (got_match.size() < n)
    begin
      if (waited >= n + RESULT_TIMEOUT)
      begin
        stop_on_failure("timeout: results missing from a tuple stream");
      end
      @(posedge clk);
      waited++;
    end
    repeat (2) @(posedge clk);
    check_value("result_count", 64'(got_match.size()), 64'(n));
    for (int k = 0; k < n; k++)
    begin
      p = want[k];
      check_value("match", 64'(got_match[k]), 64'(p[11]));
      check_value("rule_id", 64'(got_id[k]), 64'(p[10:0]));
    end
    batch_q.delete();
  endtask

  task automatic idle_after_reset();
    repeat (20)
    begin
      @(negedge clk);
      check_value("result_valid", 64'(result_valid), 64'd0);
      check_value("match", 64'(match), 64'd0);
      check_value("ack", 64'(ack), 64'd0);
    end
  endtask

  task automatic ack_and_single_match();
    classifier_pkg::tuple_t t;
    t = '{src_ip: 32'hC0A8_0001, dst_ip: 32'h0A01_0203, src_port: 16'd1234,
          dst_port: 16'd80, proto: 8'd6};
    program_seg(hash_tuple(t), 5'd3, 5'd31);
    program_rule(2'd0, 1'b0, 5'd3, 1'b1, 1'b0, 8'd6, 6'd32, 32'h0A01_0203, 11'd100, 5'd0);
    run_single(t, 1'b1, 11'd100);
    // read cycle aimed at the rule ctrl word, must leave it intact
    bus_cycle(1'b0, rule_addr(2'd0, 1'b0, 5'd3, 2'd1), 32'd0);
    // region 2 is outside the map
    wb_write(12'h80D, 32'h0000_1F1F);
    run_single(t, 1'b1, 11'd100);
  endtask

  task automatic miss_and_wildcard();
    classifier_pkg::tuple_t t;
    t = '{src_ip: 32'hC0A8_0001, dst_ip: 32'h0A01_0203, src_port: 16'd1234,
          dst_port: 16'd80, proto: 8'd17};
    program_seg(hash_tuple(t), 5'd3, 5'd31);
    run_single(t, 1'b0, 11'd0);
    program_rule(2'd0, 1'b0, 5'd4, 1'b1, 1'b0, 8'd6, 6'd24, 32'h0A01_0200, 11'h200, 5'd0);
    t.proto = 8'd6;
    t.dst_ip = 32'h0A01_02FF;
    program_seg(hash_tuple(t), 5'd4, 5'd31);
    run_single(t, 1'b1, 11'h200);
    // bit 8 lies inside the 24 bit prefix
    t.dst_ip = 32'h0A01_03FF;
    program_seg(hash_tuple(t), 5'd4, 5'd31);
    run_single(t, 1'b0, 11'd0);
    program_rule(2'd0, 1'b0, 5'd5, 1'b1, 1'b1, 8'd6, 6'd16, 32'hC0A8_0000, 11'h155, 5'd0);
    t.dst_ip = 32'hC0A8_1234;
    t.proto = 8'd17;
    program_seg(hash_tuple(t), 5'd5, 5'd31);
    run_single(t, 1'b1, 11'h155);
    program_rule(2'd0, 1'b0, 5'd6, 1'b1, 1'b1, 8'd0, 6'd0, 32'hFFFF_FFFF, 11'h321, 5'd0);
    t.dst_ip = 32'h1234_5678;
    program_seg(hash_tuple(t), 5'd6, 5'd31);
    run_single(t, 1'b1, 11'h321);
  endtask

  task automatic chain_priority();
    classifier_pkg::tuple_t t;
    t = '{src_ip: 32'h0102_0304, dst_ip: 32'hAC10_0505, src_port: 16'd5000,
          dst_port: 16'd443, proto: 8'd6};
    // group 0 walks 10 to 13, group 1 walks 20 to 23
    program_rule(2'd0, 1'b0, 5'd10, 1'b1, 1'b0, 8'd6, 6'd32, 32'hAC10_0505, 11'd50, 5'd11);
    program_rule(2'd1, 1'b0, 5'd11, 1'b1, 1'b0, 8'd17, 6'd8, 32'hAC00_0000, 11'd600, 5'd12);
    program_rule(2'd2, 1'b0, 5'd12, 1'b1, 1'b0, 8'd6, 6'd12, 32'hAC10_0000, 11'd300, 5'd13);
    program_rule(2'd3, 1'b0, 5'd13, 1'b1, 1'b1, 8'd0, 6'd16, 32'hAC10_FFFF, 11'd40, 5'd0);
    program_rule(2'd0, 1'b1, 5'd20, 1'b1, 1'b1, 8'd0, 6'd24, 32'hAC10_0500, 11'd10, 5'd21);
    program_rule(2'd1, 1'b1, 5'd21, 1'b1, 1'b1, 8'd0, 6'd0, 32'h0000_0000, 11'd450, 5'd22);
    program_rule(2'd2, 1'b1, 5'd22, 1'b1, 1'b0, 8'd6, 6'd32, 32'hAC10_0504, 11'd700, 5'd23);
    program_rule(2'd3, 1'b1, 5'd23, 1'b1, 1'b0, 8'd6, 6'd20, 32'hAC10_0000, 11'd200, 5'd0);
    program_seg(hash_tuple(t), 5'd10, 5'd20);
    run_single(t, 1'b1, 11'd450);
    t.proto = 8'd17;
    program_seg(hash_tuple(t), 5'd10, 5'd20);
    batch_q.push_back(t);
    t.proto = 8'd6;
    t.dst_ip = 32'hAC10_0504;
    program_seg(hash_tuple(t), 5'd10, 5'd20);
    batch_q.push_back(t);
    send_batch();
  endtask

  task automatic random_streaming();
    logic [31:0]            r1;
    logic [31:0]            r2;
    logic [31:0]            r3;
    logic [31:0]            r4;
    logic [4:0]             pick;
    logic [5:0]             plen;
    classifier_pkg::tuple_t t;
    for (int s = 0; s < 16; s++)
    begin
      r1 = $random(seed);
      program_seg(4'(s), r1[4:0], r1[12:8]);
    end
    for (int s = 0; s < 4; s++)
    begin
      for (int g = 0; g < 2; g++)
      begin
        for (int i = 0; i < 32; i++)
        begin
          r1 = $random(seed);
          r2 = $random(seed);
          r3 = $random(seed);
          r4 = $random(seed);
          // mostly short prefixes, some lengths past 32
          pick = r1[8:4];
          plen = (pick < 5'd24) ? {2'b00, pick[3:0]} : ({1'b0, pick} + 6'd16);
          program_rule(2'(s), 1'(g), 5'(i), r1[0] | r1[1], r1[2],
                       r1[3] ? 8'd6 : 8'd17, plen, {12'h0A0, r2[19:0]}, r3[10:0], r4[4:0]);
        end
      end
    end
    for (int k = 0; k < 64; k++)
    begin
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      r4 = $random(seed);
      t = '{src_ip: r1, dst_ip: {12'h0A0, r2[19:0]}, src_port: r3[15:0],
            dst_port: r3[31:16], proto: r4[0] ? 8'd6 : 8'd17};
      batch_q.push_back(t);
    end
    send_batch();
  endtask

  initial
  begin
    seed = 91;
    negedge_count = 0;
    wb = '0;
    tuple_valid = 1'b0;
    tuple = '0;
    model_clear();
    wait_reset_release();
    idle_after_reset();
    ack_and_single_match();
    miss_and_wildcard();
    chain_priority();
    random_streaming();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/classifier_pkg.sv
design/table_config_port.sv
design/tuple_hash_stage.sv
design/rule_search_stage.sv
design/best_rule_select.sv
design/packet_classifier.sv
verification/tb_clock_gen.sv
verification/packet_classifier_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the classifier testbench with Verilator
# exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f \
  --top-module packet_classifier_tb \
  -o packet_classifier_sim \
  && ./obj_dir/packet_classifier_sim \
  || { echo "simulation run failed"; exit 1; }
